/* source/calc_pkg.sv */
`default_nettype none

package calc_pkg;

    // ----------------------------------------
    // timing, one CLKOP domain
    // ----------------------------------------
    localparam int CLKS_PER_OS_TICK = 4;    // clocks per oversample tick
    localparam int OS_PER_BIT       = 16;   // 64 clocks per bit
    localparam int OS_MID_BIT       = 7;    // sample point inside a bit
    localparam int DATA_BITS        = 8;    // 8N1 only

    // receiver FSM codes
    localparam logic [1:0] RX_IDLE  = 2'd0;
    localparam logic [1:0] RX_START = 2'd1;
    localparam logic [1:0] RX_DATA  = 2'd2;
    localparam logic [1:0] RX_STOP  = 2'd3;

    // ----------------------------------------
    // character codes
    // ----------------------------------------
    localparam logic [7:0] CHAR_PLUS   = 8'h2B;  // '+'
    localparam logic [7:0] CHAR_MINUS  = 8'h2D;  // '-'
    localparam logic [3:0] DIGIT_ZONE  = 4'h3;   // upper nibble of '0'..'?'
    localparam logic [7:0] RESULT_BASE = 8'h40;  // result maps onto '@'..'_'

    // 4-bit operand
    typedef logic [3:0] nibble_t;

    // one received byte, seen two ways
    // chr for operator compares, nib[1] zone and nib[0] value for digits
    typedef union packed {
        logic [7:0]    chr;
        nibble_t [1:0] nib;
    } calc_char_u;

endpackage

`default_nettype wire

/* source/baud_tick_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module baud_tick_gen #(
    parameter int CLKS_PER_TICK = 4,   // prescale to oversample rate
    parameter int TICKS_PER_BIT = 16   // oversample ticks per bit
) (
    input  wire  CLKOP,
    input  wire  i_rst,
    output logic o_os_tick,
    output logic o_bit_tick
);

    logic [$clog2(CLKS_PER_TICK)-1:0] pre_cnt;
    logic [$clog2(TICKS_PER_BIT)-1:0] os_cnt;
    logic                             pre_wrap;
    logic                             os_wrap;

    assign pre_wrap = (pre_cnt == $bits(pre_cnt)'(CLKS_PER_TICK - 1));
    assign os_wrap  = (os_cnt == $bits(os_cnt)'(TICKS_PER_BIT - 1));

    // free running, both ticks are single-cycle strobes
    always_ff @(posedge CLKOP) begin
        if (i_rst) begin
            pre_cnt    <= '0;
            os_cnt     <= '0;
            o_os_tick  <= 1'b0;
            o_bit_tick <= 1'b0;
        end else begin
            pre_cnt    <= pre_wrap ? '0 : pre_cnt + 1'b1;
            o_os_tick  <= pre_wrap;            // every CLKS_PER_TICK clocks
            o_bit_tick <= pre_wrap && os_wrap; // once per 16 os ticks
            if (pre_wrap) begin
                os_cnt <= os_wrap ? '0 : os_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/uart_rx.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_rx (
    input  wire                  CLKOP,
    input  wire                  i_rst,
    input  wire                  i_os_tick,
    input  wire                  i_serial_data,
    output logic                 o_rx_valid,
    output calc_pkg::calc_char_u o_rx_char
);
    import calc_pkg::*;

    logic       rx_meta;
    logic       rx_sync;
    logic [1:0] state;
    logic [3:0] os_cnt;     // position inside current bit
    logic [2:0] bit_cnt;
    logic [7:0] shift_q;
    logic       stop_err;   // low stop bit, wait for line to go idle
    logic       mid_bit;
    logic       end_bit;

    // two-flop synchronizer, idles high
    always_ff @(posedge CLKOP) begin
        if (i_rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= i_serial_data;
            rx_sync <= rx_meta;
        end
    end

    assign mid_bit = (os_cnt == 4'(OS_MID_BIT));
    assign end_bit = (os_cnt == 4'(OS_PER_BIT - 1));

    // ----------------------------------------
    // frame FSM, advances on os ticks only
    // ----------------------------------------
    always_ff @(posedge CLKOP) begin
        if (i_rst) begin
            state      <= RX_IDLE;
            os_cnt     <= '0;
            bit_cnt    <= '0;
            stop_err   <= 1'b0;
            o_rx_valid <= 1'b0;
        end else begin
            o_rx_valid <= 1'b0;
            if (i_os_tick) begin
                os_cnt <= end_bit ? 4'd0 : os_cnt + 4'd1;
                case (state)
                    RX_IDLE: begin
                        os_cnt <= 4'd1;                // edge tick is count 0
                        if (!rx_sync) state <= RX_START;
                    end
                    RX_START: begin
                        if (mid_bit && rx_sync) begin
                            state <= RX_IDLE;          // glitch, not a start bit
                        end else if (end_bit) begin
                            state   <= RX_DATA;
                            bit_cnt <= '0;
                        end
                    end
                    RX_DATA: begin
                        if (end_bit) begin
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'(DATA_BITS - 1)) state <= RX_STOP;
                        end
                    end
                    default: begin                     // RX_STOP
                        if (stop_err) begin
                            if (rx_sync) begin
                                stop_err <= 1'b0;
                                state    <= RX_IDLE;
                            end
                        end else if (mid_bit) begin
                            o_rx_valid <= rx_sync;     // bad frame gives no pulse
                            stop_err   <= !rx_sync;
                            if (rx_sync) state <= RX_IDLE;
                        end
                    end
                endcase
            end
        end
    end

    // data path, LSB first
    always_ff @(posedge CLKOP) begin
        if (i_os_tick && mid_bit && state == RX_DATA) begin
            shift_q <= {rx_sync, shift_q[7:1]};
        end
        if (i_os_tick && mid_bit && state == RX_STOP && !stop_err && rx_sync) begin
            o_rx_char <= shift_q;   // held until next frame
        end
    end

endmodule

`default_nettype wire

/* source/calc_parser.sv */
`timescale 1ns/100ps
`default_nettype none

module calc_parser (
    input  wire                       CLKOP,
    input  wire                       i_rst,
    input  wire                       i_rx_valid,
    input  wire calc_pkg::calc_char_u i_rx_char,
    output logic                      o_calc_go,
    output calc_pkg::nibble_t         o_opnd_a,
    output calc_pkg::nibble_t         o_opnd_b,
    output logic                      o_sub
);
    import calc_pkg::*;

    logic [1:0] pos;        // 0 first digit, 1 second digit, 2 operator
    logic       is_digit;
    logic       is_plus;
    logic       is_minus;

    // ----------------------------------------
    // character decode
    // ----------------------------------------
    assign is_digit = (i_rx_char.nib[1] == DIGIT_ZONE);  // zone nibble
    assign is_plus  = (i_rx_char.chr == CHAR_PLUS);
    assign is_minus = (i_rx_char.chr == CHAR_MINUS);

    // ----------------------------------------
    // sequence tracking
    // ----------------------------------------
    always_ff @(posedge CLKOP) begin
        if (i_rst) begin
            pos       <= 2'd0;
            o_calc_go <= 1'b0;
            o_opnd_a  <= '0;   // partial operands are dropped on reset
            o_opnd_b  <= '0;
            o_sub     <= 1'b0;
        end else begin
            o_calc_go <= 1'b0;
            if (i_rx_valid) begin
                case (pos)
                    2'd0: begin
                        if (is_digit) begin
                            o_opnd_a <= i_rx_char.nib[0];
                            pos      <= 2'd1;
                        end
                    end
                    2'd1: begin
                        if (is_digit) begin
                            o_opnd_b <= i_rx_char.nib[0];
                            pos      <= 2'd2;
                        end else begin
                            pos <= 2'd0;       // broken, start over
                        end
                    end
                    default: begin
                        pos <= 2'd0;           // third byte always ends it
                        if (is_plus || is_minus) begin
                            o_calc_go <= 1'b1;
                            o_sub     <= is_minus;
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* source/calc_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module calc_alu (
    input  wire                    CLKOP,
    input  wire                    i_rst,
    input  wire                    i_calc_go,
    input  wire calc_pkg::nibble_t i_opnd_a,
    input  wire calc_pkg::nibble_t i_opnd_b,
    input  wire                    i_sub,
    output logic                   o_res_valid,
    output logic [7:0]             o_res_char
);
    import calc_pkg::*;

    nibble_t    b_eff;
    logic [4:0] sum;       // bit 4 is carry out

    // subtract as a + ~b + 1
    always_comb begin
        b_eff = i_sub ? ~i_opnd_b : i_opnd_b;
        sum   = {1'b0, i_opnd_a} + {1'b0, b_eff} + {4'd0, i_sub};
    end

    // ----------------------------------------
    // result register
    // ----------------------------------------
    always_ff @(posedge CLKOP) begin
        if (i_rst) begin
            o_res_valid <= 1'b0;
        end else begin
            o_res_valid <= i_calc_go;      // one cycle after go
        end
    end

    always_ff @(posedge CLKOP) begin
        if (i_calc_go) begin
            o_res_char <= RESULT_BASE + {3'b000, sum};  // '@'..'_'
        end
    end

endmodule

`default_nettype wire

/* source/tx_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module tx_arbiter (
    input  wire                       CLKOP,
    input  wire                       i_rst,
    input  wire                       i_rx_valid,
    input  wire calc_pkg::calc_char_u i_rx_char,
    input  wire                       i_res_valid,
    input  wire [7:0]                 i_res_char,
    input  wire                       i_tx_busy,
    output logic                      o_tx_start,
    output logic [7:0]                o_tx_char
);

    logic       echo_full;
    logic       res_full;
    logic [7:0] echo_char;
    logic [7:0] res_char;
    logic       can_launch;
    logic       pick_echo;
    logic       pick_res;

    // busy rises one cycle late, so skip the cycle after our own start
    assign can_launch = !i_tx_busy && !o_tx_start;
    assign pick_echo  = can_launch && echo_full;             // echo wins
    assign pick_res   = can_launch && !echo_full && res_full;

    // ----------------------------------------
    // slot flags and start strobe
    // ----------------------------------------
    always_ff @(posedge CLKOP) begin
        if (i_rst) begin
            echo_full  <= 1'b0;
            res_full   <= 1'b0;
            o_tx_start <= 1'b0;
        end else begin
            o_tx_start <= pick_echo || pick_res;
            if (pick_echo) echo_full <= 1'b0;
            if (pick_res)  res_full  <= 1'b0;
            if (i_rx_valid)  echo_full <= 1'b1;   // new byte overwrites a full slot
            if (i_res_valid) res_full  <= 1'b1;
        end
    end

    // slot payloads and outgoing byte
    always_ff @(posedge CLKOP) begin
        if (i_rx_valid)  echo_char <= i_rx_char.chr;
        if (i_res_valid) res_char  <= i_res_char;
        if (pick_echo) begin
            o_tx_char <= echo_char;
        end else if (pick_res) begin
            o_tx_char <= res_char;
        end
    end

endmodule

`default_nettype wire

/* source/uart_tx.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_tx (
    input  wire       CLKOP,
    input  wire       i_rst,
    input  wire       i_bit_tick,
    input  wire       i_tx_start,
    input  wire [7:0] i_tx_char,
    output logic      o_tx_busy,
    output logic      o_serial_data
);
    import calc_pkg::*;

    logic [9:0] frame_q;    // stop, data, start
    logic [3:0] bit_cnt;    // bits already on the line
    logic       frame_done;

    assign frame_done = (bit_cnt == 4'(DATA_BITS + 2));

    // ----------------------------------------
    // control
    // ----------------------------------------
    always_ff @(posedge CLKOP) begin
        if (i_rst) begin
            o_tx_busy     <= 1'b0;
            o_serial_data <= 1'b1;     // line idle
            bit_cnt       <= '0;
        end else begin
            if (!o_tx_busy) begin
                if (i_tx_start) begin
                    o_tx_busy <= 1'b1;     // visible the cycle after start
                    bit_cnt   <= '0;
                end
            end else if (i_bit_tick) begin
                if (frame_done) begin
                    o_tx_busy <= 1'b0;     // tick that closes the stop bit
                end else begin
                    o_serial_data <= frame_q[0];
                    bit_cnt       <= bit_cnt + 4'd1;
                end
            end
        end
    end

    // ----------------------------------------
    // frame shifter
    // ----------------------------------------
    always_ff @(posedge CLKOP) begin
        if (!o_tx_busy && i_tx_start) begin
            frame_q <= {1'b1, i_tx_char, 1'b0};
        end else if (o_tx_busy && i_bit_tick) begin
            frame_q <= {1'b1, frame_q[9:1]};   // LSB out first
        end
    end

endmodule

`default_nettype wire

/* source/calc_uart_top.sv */
`timescale 1ns/100ps
`default_nettype none

module calc_uart_top (
    input  wire CLKOP,
    input  wire i_rst,
    input  wire i_serial_data,
    output wire o_serial_data
);
    import calc_pkg::*;

    wire        os_tick;
    wire        bit_tick;
    wire        rx_valid;
    calc_char_u rx_char;
    wire        calc_go;
    nibble_t    opnd_a;
    nibble_t    opnd_b;
    wire        sub;
    wire        res_valid;
    wire [7:0]  res_char;
    wire        tx_start;
    wire [7:0]  tx_char;
    wire        tx_busy;

    // ----------------------------------------
    // ticks and receive
    // ----------------------------------------
    baud_tick_gen #(
        .CLKS_PER_TICK (CLKS_PER_OS_TICK),
        .TICKS_PER_BIT (OS_PER_BIT)
    ) u_ticks (
        .CLKOP(CLKOP), .i_rst(i_rst), .o_os_tick(os_tick), .o_bit_tick(bit_tick)
    );

    uart_rx u_rx (
        .CLKOP(CLKOP), .i_rst(i_rst), .i_os_tick(os_tick), .i_serial_data(i_serial_data),
        .o_rx_valid(rx_valid), .o_rx_char(rx_char)
    );

    // parse and compute
    calc_parser u_parser (
        .CLKOP(CLKOP), .i_rst(i_rst), .i_rx_valid(rx_valid), .i_rx_char(rx_char),
        .o_calc_go(calc_go), .o_opnd_a(opnd_a), .o_opnd_b(opnd_b), .o_sub(sub)
    );

    calc_alu u_alu (
        .CLKOP(CLKOP), .i_rst(i_rst), .i_calc_go(calc_go), .i_opnd_a(opnd_a),
        .i_opnd_b(opnd_b), .i_sub(sub), .o_res_valid(res_valid), .o_res_char(res_char)
    );

    // ----------------------------------------
    // echo/result arbitration and transmit
    // ----------------------------------------
    tx_arbiter u_arb (
        .CLKOP(CLKOP), .i_rst(i_rst), .i_rx_valid(rx_valid), .i_rx_char(rx_char),
        .i_res_valid(res_valid), .i_res_char(res_char), .i_tx_busy(tx_busy),
        .o_tx_start(tx_start), .o_tx_char(tx_char)
    );

    uart_tx u_tx (
        .CLKOP(CLKOP), .i_rst(i_rst), .i_bit_tick(bit_tick), .i_tx_start(tx_start),
        .i_tx_char(tx_char), .o_tx_busy(tx_busy), .o_serial_data(o_serial_data)
    );

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic o_clk
);

    // 10 ns period, starts low
    initial begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

/* tb/calc_uart_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module calc_uart_tb;
    import calc_pkg::*;

    localparam int CLKS_PER_BIT = CLKS_PER_OS_TICK * OS_PER_BIT;  // 64
    localparam int FRAME_CLKS   = 10 * CLKS_PER_BIT;
    localparam int EV_RESET     = -1;       // reset pulse between bytes
    localparam int EV_BAD_STOP  = 'h100;    // byte sent with a low stop bit

    typedef int         ev_q_t[$];
    typedef logic [7:0] byte_q_t[$];

    logic    CLKOP;
    logic    i_rst;
    logic    i_serial_data;
    wire     o_serial_data;

    int      seed = 40;
    int      cycle_cnt = 0;
    int      timeout_limit = 0;     // known once stimulus is built
    ev_q_t   events;                // everything put on the line, in order
    byte_q_t exp_q;
    byte_q_t obs_q;                 // bytes decoded from o_serial_data

    tb_clock_gen u_clk (.o_clk(CLKOP));

    calc_uart_top DUT (
        .CLKOP(CLKOP), .i_rst(i_rst), .i_serial_data(i_serial_data),
        .o_serial_data(o_serial_data)
    );

    // ----------------------------------------
    // error reporting
    // ----------------------------------------
    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got 0x%02h expected 0x%02h", $time, name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "first mismatch");
        end
    endtask

    task automatic fail_now(input string what);
        $display("%s (t=%0t)", what, $time);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    // ----------------------------------------
    // reference model of the output stream
    // ----------------------------------------
    function automatic byte_q_t calc_expected(input ev_q_t ev);
        byte_q_t    out;
        int         pos;            // 0 first digit, 1 second, 2 operator
        int         k;
        logic [7:0] ch;
        logic [3:0] a;
        logic [3:0] b;
        logic [4:0] res;            // carry in bit 4
        pos = 0;
        a   = '0;
        b   = '0;
        for (k = 0; k < ev.size(); k++) begin
            if (ev[k] == EV_RESET) begin
                pos = 0;            // partial operands gone
                a   = '0;
                b   = '0;
            end else if (ev[k] < EV_BAD_STOP) begin    // bad frames never seen
                ch = 8'(ev[k]);
                out.push_back(ch);                     // echo first
                if (pos == 0) begin
                    if (ch[7:4] == 4'h3) begin
                        a   = ch[3:0];
                        pos = 1;
                    end
                end else if (pos == 1) begin
                    b   = ch[3:0];
                    pos = (ch[7:4] == 4'h3) ? 2 : 0;   // non-digit restarts
                end else begin
                    pos = 0;
                    if (ch == 8'h2B || ch == 8'h2D) begin
                        res = (ch == 8'h2B) ? {1'b0, a} + {1'b0, b}
                                            : {1'b0, a} + {1'b0, ~b} + 5'd1;
                        out.push_back(8'h40 + {3'b000, res});   // '@'..'_'
                    end
                end
            end
        end
        return out;
    endfunction

    // digit, operator or a letter that breaks the sequence (one in four)
    function automatic logic [7:0] rand_item(input bit want_op);
        logic [7:0] r;
        r = 8'($random(seed));
        if (r[7:6] == 2'b00) return 8'h41 + 8'(r[5:0] % 26);
        if (want_op) return r[0] ? 8'h2D : 8'h2B;
        return {4'h3, r[3:0]};
    endfunction

    task automatic push_triple(input logic [7:0] c0, input logic [7:0] c1,
                               input logic [7:0] c2);
        events.push_back(int'(c0));
        events.push_back(int'(c1));
        events.push_back(int'(c2));
    endtask

    task automatic build_stimulus();
        int         i;
        logic [7:0] c0;
        logic [7:0] c1;
        logic [7:0] c2;
        for (i = 0; i < 20; i++) events.push_back($random(seed) & 'hFF);  // echo run
        events.push_back('h58);                 // 'X' clears any partial triple
        push_triple(8'h33, 8'h35, 8'h2B);       // 'H'
        push_triple(8'h3F, 8'h3F, 8'h2B);       // 15+15 = 0x5E
        push_triple(8'h37, 8'h32, 8'h2D);       // 'U', carry set
        push_triple(8'h32, 8'h37, 8'h2D);       // 'K', carry clear
        for (i = 0; i < 30; i++) begin
            c0 = rand_item(1'b0);
            c1 = rand_item(1'b0);
            c2 = rand_item(1'b1);
            push_triple(c0, c1, c2);
        end
        events.push_back('h58);
        // middle '5' has a low stop bit, so 4+6
        events.push_back('h34);
        events.push_back(EV_BAD_STOP | 'h35);
        push_triple(8'h36, 8'h2B, 8'h58);
        // reset after two digits, then 9-1 from scratch
        events.push_back('h38);
        events.push_back('h36);
        events.push_back(EV_RESET);
        push_triple(8'h39, 8'h31, 8'h2D);
    endtask

    // ----------------------------------------
    // line drivers, all on the falling edge
    // ----------------------------------------
    task automatic send_frame(input logic [7:0] data, input logic stop_bit);
        logic [9:0] bits;
        int         i;
        bits = {stop_bit, data, 1'b0};
        for (i = 0; i < 10; i++) begin
            i_serial_data = bits[i];            // start, LSB first, stop
            repeat (CLKS_PER_BIT) @(negedge CLKOP);
        end
        i_serial_data = 1'b1;
        repeat (FRAME_CLKS) @(negedge CLKOP);   // idle frame
    endtask

    task automatic pulse_reset(input int cycles);
        int i;
        i_rst = 1'b1;
        for (i = 0; i < cycles; i++) begin
            @(negedge CLKOP);
            check_value("o_serial_data in reset", {7'd0, o_serial_data}, 8'd1);
        end
        i_rst = 1'b0;
    endtask

    initial begin : run_test
        int i;
        int n_bytes;
        int n_echo;
        i_rst         = 1'b1;
        i_serial_data = 1'b1;       // line idle
        n_bytes       = 0;
        n_echo        = 0;
        build_stimulus();
        exp_q = calc_expected(events);
        for (i = 0; i < events.size(); i++) begin
            if (events[i] != EV_RESET) n_bytes++;
            if (events[i] >= 0 && events[i] < EV_BAD_STOP) n_echo++;
        end
        // two frames per byte or result, plus reset gaps and tail
        timeout_limit = 2 * (n_bytes + exp_q.size() - n_echo) * FRAME_CLKS + 20 * FRAME_CLKS;
        pulse_reset(10);
        for (i = 0; i < events.size(); i++) begin
            if (events[i] == EV_RESET) begin
                repeat (2 * FRAME_CLKS) @(negedge CLKOP);   // tx idle first
                pulse_reset(10);
            end else begin
                send_frame(8'(events[i]), events[i] < EV_BAD_STOP);
            end
        end
        i = 0;
        while (exp_q.size() != 0 && i < 4 * FRAME_CLKS) begin
            @(negedge CLKOP);
            i++;
        end
        repeat (2 * FRAME_CLKS) @(negedge CLKOP);       // room for stray bytes
        if (exp_q.size() != 0) begin
            $display("run ended with %0d expected bytes that never arrived", exp_q.size());
            $display("CHECKS FAILED");
            $fatal(1, "missing output");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

    // ----------------------------------------
    // output decoder and compare
    // ----------------------------------------
    initial begin : decode_serial
        logic [7:0] rx_byte;
        int         b;
        repeat (12) @(negedge CLKOP);                   // past power-on reset
        forever begin
            @(negedge o_serial_data);
            repeat (CLKS_PER_BIT / 2) @(negedge CLKOP); // mid start bit
            if (o_serial_data !== 1'b0) fail_now("start bit on o_serial_data not low");
            for (b = 0; b < 8; b++) begin
                repeat (CLKS_PER_BIT) @(negedge CLKOP);
                rx_byte[b] = o_serial_data;
            end
            repeat (CLKS_PER_BIT) @(negedge CLKOP);
            if (o_serial_data !== 1'b1) fail_now("stop bit on o_serial_data was low");
            obs_q.push_back(rx_byte);
        end
    end

    initial begin : compare_bytes
        logic [7:0] got;
        int         n;
        n = 0;
        forever begin
            @(posedge CLKOP);
            if (obs_q.size() > 0) begin
                got = obs_q.pop_front();
                if (exp_q.size() == 0) begin
                    fail_now($sformatf("unexpected byte 0x%02h on o_serial_data", got));
                end else begin
                    check_value($sformatf("o_serial_data byte %0d", n), got, exp_q.pop_front());
                end
                n++;
            end
        end
    end

    // hang guard
    always @(posedge CLKOP) begin
        cycle_cnt <= cycle_cnt + 1;
        if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
            fail_now($sformatf("timeout after %0d cycles, output stalled", cycle_cnt));
        end
    end

endmodule

`default_nettype wire

/* sim.f */
source/calc_pkg.sv
source/baud_tick_gen.sv
source/uart_rx.sv
source/calc_parser.sv
source/calc_alu.sv
source/tx_arbiter.sv
source/uart_tx.sv
source/calc_uart_top.sv
tb/tb_clock_gen.sv
tb/calc_uart_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing
TOP       = calc_uart_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)
